// File: hdl/zx_defines.svh
`ifndef ZX_DEFINES_SVH
`define ZX_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// memory layout
//////////////////////////////////////////////////////////////////////

// four 16k windows over the z80 space
`define ZX_NUM_WIN 4

// page field widths
`define ZX_ROM_PG_W 5
`define ZX_RAM_PG_W 7

//////////////////////////////////////////////////////////////////////
// port addresses
//////////////////////////////////////////////////////////////////////

// full decode
`define ZX_PORT_EFF7 16'hEFF7

// low byte decode only
`define ZX_PORT_LO_F7 8'hF7
`define ZX_PORT_LO_77 8'h77
`define ZX_PORT_LO_FE 8'hFE

// opcode fetch from 3Dxx arms the dos rom
`define ZX_DOS_TRAP_HI 8'h3D

`endif

// File: hdl/zx_pkg.sv
package zx_pkg;

	`include "zx_defines.svh"

	// ram view of a page byte
	typedef struct packed {
		logic                    is_ram;
		logic [`ZX_RAM_PG_W-1:0] page;
	} page_ram_t;

	// rom view, same flag position
	typedef struct packed {
		logic                    is_ram;
		logic [1:0]              rsvd;
		logic [`ZX_ROM_PG_W-1:0] page;
	} page_rom_t;

	// flag bit picks the valid view
	typedef union packed {
		page_ram_t  ram;
		page_rom_t  rom;
		logic [7:0] raw;
	} page_word_t;

	function automatic page_word_t mk_ram_page(input logic [`ZX_RAM_PG_W-1:0] pg);
		page_word_t w;
		w.ram.is_ram = 1'b1;
		w.ram.page   = pg;
		return w;
	endfunction

	function automatic page_word_t mk_rom_page(input logic [`ZX_ROM_PG_W-1:0] pg);
		page_word_t w;
		w.rom.is_ram = 1'b0;
		w.rom.rsvd   = 2'b00;
		w.rom.page   = pg;
		return w;
	endfunction

	// two active low z80 strobes asserted together
	function automatic logic both_low(input logic a_n, input logic b_n);
		return ~a_n & ~b_n;
	endfunction

	// partial port decode on the low address byte
	function automatic logic lo_port_hit(input logic [15:0] addr, input logic [7:0] lo);
		return addr[7:0] == lo;
	endfunction

endpackage

// File: hdl/zx_ifaces.sv
`timescale 1ns/1ps

//////////////////////////////////////////////////////////////////////
// decoded z80 bus cycles
//////////////////////////////////////////////////////////////////////

interface z80_cycle_if;
	// one fclk pulse per cycle start
	logic        io_wr;
	logic        m1_fetch;
	// level while the read lasts
	logic        io_rd;
	logic [15:0] addr;
	logic [7:0]  wdata;

	modport source (
		output io_wr,
		output io_rd,
		output m1_fetch,
		output addr,
		output wdata
	);

	modport sink (
		input io_wr,
		input io_rd,
		input m1_fetch,
		input addr,
		input wdata
	);
endinterface

//////////////////////////////////////////////////////////////////////
// configuration port state
//////////////////////////////////////////////////////////////////////

interface port_cfg_if;
	logic [7:0] p7ffd;
	logic [7:0] peff7;
	logic       pager_on;
	logic       cpm_n;

	modport source (
		output p7ffd,
		output peff7,
		output pager_on,
		output cpm_n
	);

	modport sink (
		input p7ffd,
		input peff7,
		input pager_on,
		input cpm_n
	);
endinterface

// File: hdl/z80_bus_decoder.sv
`timescale 1ns/1ps

module z80_bus_decoder
	import zx_pkg::*;
(
	input  logic        fclk,
	input  logic        rst,
	input  logic [15:0] a,
	input  logic [7:0]  d_in,
	input  logic        iorq_n,
	input  logic        mreq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	input  logic        m1_n,
	z80_cycle_if.source bus
);

	// first stage, raw pin samples
	logic [15:0] s_a;
	logic [7:0]  s_d;
	logic        s_iorq_n;
	logic        s_mreq_n;
	logic        s_rd_n;
	logic        s_wr_n;
	logic        s_m1_n;

	// cycle levels and their previous values
	logic io_wr_lvl;
	logic m1_lvl;
	logic io_wr_lvl_q;
	logic m1_lvl_q;

	always_ff @(posedge fclk)
	begin
		s_a <= a;
		s_d <= d_in;
		if (rst)
		begin
			s_iorq_n <= 1'b1;
			s_mreq_n <= 1'b1;
			s_rd_n   <= 1'b1;
			s_wr_n   <= 1'b1;
			s_m1_n   <= 1'b1;
		end
		else
		begin
			s_iorq_n <= iorq_n;
			s_mreq_n <= mreq_n;
			s_rd_n   <= rd_n;
			s_wr_n   <= wr_n;
			s_m1_n   <= m1_n;
		end
	end

	assign io_wr_lvl = both_low(s_iorq_n, s_wr_n);
	assign m1_lvl    = both_low(s_mreq_n, s_m1_n);

	// address and data line up with the strobes
	always_ff @(posedge fclk)
	begin
		bus.addr  <= s_a;
		bus.wdata <= s_d;
	end

	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			io_wr_lvl_q  <= 1'b0;
			m1_lvl_q     <= 1'b0;
			bus.io_wr    <= 1'b0;
			bus.m1_fetch <= 1'b0;
			bus.io_rd    <= 1'b0;
		end
		else
		begin
			io_wr_lvl_q  <= io_wr_lvl;
			m1_lvl_q     <= m1_lvl;
			// falling edge of the sampled cycle
			bus.io_wr    <= io_wr_lvl & ~io_wr_lvl_q;
			bus.m1_fetch <= m1_lvl & ~m1_lvl_q;
			bus.io_rd    <= both_low(s_iorq_n, s_rd_n);
		end
	end

endmodule

// File: hdl/port_regs.sv
`timescale 1ns/1ps

`include "zx_defines.svh"

module port_regs
	import zx_pkg::*;
(
	input  logic        fclk,
	input  logic        rst,
	z80_cycle_if.sink   bus,
	port_cfg_if.source  cfg,
	output logic [7:0]  d_out,
	output logic        d_oe,
	output logic [2:0]  border,
	output logic        beep
);

	logic hit_7ffd;
	logic hit_eff7;
	logic hit_77;
	logic hit_fe;
	logic lock_7ffd;

	//////////////////////////////////////////////////////////////////////
	// address decode
	//////////////////////////////////////////////////////////////////////

	// pentagon style, only A15 and A1
	assign hit_7ffd = ~bus.addr[15] & ~bus.addr[1];
	assign hit_eff7 = bus.addr == `ZX_PORT_EFF7;
	assign hit_77   = lo_port_hit(bus.addr, `ZX_PORT_LO_77);
	assign hit_fe   = lo_port_hit(bus.addr, `ZX_PORT_LO_FE);

	// bit 5 freezes 7ffd until reset
	assign lock_7ffd = cfg.p7ffd[5];

	//////////////////////////////////////////////////////////////////////
	// write side
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			cfg.p7ffd    <= 8'h00;
			cfg.peff7    <= 8'h00;
			cfg.pager_on <= 1'b0;
			cfg.cpm_n    <= 1'b1;
			border       <= 3'd0;
			beep         <= 1'b0;
		end
		else if (bus.io_wr)
		begin
			if (hit_7ffd && !lock_7ffd)
				cfg.p7ffd <= bus.wdata;
			if (hit_eff7)
				cfg.peff7 <= bus.wdata;
			// atm config, mode bits ride on the high address byte
			if (hit_77)
			begin
				cfg.pager_on <= bus.addr[8];
				cfg.cpm_n    <= bus.addr[9];
			end
			if (hit_fe)
			begin
				border <= bus.wdata[2:0];
				beep   <= bus.wdata[4];
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// readback
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		d_out <= hit_eff7 ? cfg.peff7 : cfg.p7ffd;
	end

	always_ff @(posedge fclk)
	begin
		if (rst)
			d_oe <= 1'b0;
		else
			d_oe <= bus.io_rd & (hit_7ffd | hit_eff7);
	end

endmodule

// File: hdl/window_pager.sv
`timescale 1ns/1ps

`include "zx_defines.svh"

module window_pager
	import zx_pkg::*;
#(
	parameter int WIN = 0
)
(
	input  logic       fclk,
	input  logic       rst,
	z80_cycle_if.sink  bus,
	port_cfg_if.sink   cfg,
	input  logic       dos,
	output page_word_t page
);

	page_word_t page_q;
	page_word_t pent_page;
	logic       wr_hit;
	logic [1:0] ext_hi;

	// xxF7 with the window index on A15..A14
	assign wr_hit = bus.io_wr
		& lo_port_hit(bus.addr, `ZX_PORT_LO_F7)
		& (bus.addr[15:14] == 2'(WIN));

	always_ff @(posedge fclk)
	begin
		if (rst)
			page_q <= mk_rom_page('0);
		else if (wr_hit)
			page_q.raw <= bus.wdata;
	end

	// eff7 bit 2 turns off the 512k extension
	assign ext_hi = cfg.peff7[2] ? 2'b00 : cfg.p7ffd[7:6];

	//////////////////////////////////////////////////////////////////////
	// pentagon fallback layout
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (WIN)
			0:
			begin
				// ram0 at 0000 when eff7 bit 3 is set
				if (cfg.peff7[3])
					pent_page = mk_ram_page('0);
				else
					pent_page = mk_rom_page({3'b000, dos, cfg.p7ffd[4]});
			end
			1:
				pent_page = mk_ram_page(7'd5);
			2:
				pent_page = mk_ram_page(7'd2);
			default:
				pent_page = mk_ram_page({2'b00, ext_hi, cfg.p7ffd[2:0]});
		endcase
	end

	assign page = cfg.pager_on ? page_q : pent_page;

endmodule

// File: hdl/mem_mapper.sv
`timescale 1ns/1ps

`include "zx_defines.svh"

module mem_mapper
	import zx_pkg::*;
(
	input  logic                    fclk,
	input  logic                    rst,
	z80_cycle_if.sink               bus,
	port_cfg_if.sink                cfg,
	input  page_word_t              win_page [`ZX_NUM_WIN],
	input  logic [1:0]              a_hi,
	input  logic                    mreq_n,
	input  logic                    rd_n,
	output logic                    dos,
	output logic                    dos_n,
	output logic                    csrom,
	output logic                    romoe_n,
	output logic [`ZX_ROM_PG_W-1:0] rompg,
	output logic [`ZX_RAM_PG_W-1:0] ram_page
);

	logic       dos_on;
	logic       dos_off;
	page_word_t sel;

	//////////////////////////////////////////////////////////////////////
	// dos trap
	//////////////////////////////////////////////////////////////////////

	// fetch from 3Dxx while basic48 rom sits in window 0
	assign dos_on = bus.m1_fetch
		& (bus.addr[15:8] == `ZX_DOS_TRAP_HI)
		& ~win_page[0].rom.is_ram
		& cfg.p7ffd[4];

	// any fetch outside the rom window leaves dos
	assign dos_off = bus.m1_fetch & (bus.addr[15:14] != 2'b00);

	always_ff @(posedge fclk)
	begin
		if (rst)
			dos <= 1'b0;
		else if (!cfg.cpm_n)
			dos <= 1'b1;
		else if (dos_on)
			dos <= 1'b1;
		else if (dos_off)
			dos <= 1'b0;
	end

	assign dos_n = ~dos;

	//////////////////////////////////////////////////////////////////////
	// window decode
	//////////////////////////////////////////////////////////////////////

	assign sel      = win_page[a_hi];
	assign csrom    = ~sel.ram.is_ram;
	assign rompg    = csrom ? sel.rom.page : '0;
	assign ram_page = csrom ? '0 : sel.ram.page;

	// rom output enable only on a real memory read
	assign romoe_n = ~(csrom & both_low(mreq_n, rd_n));

endmodule

// File: hdl/zx_mem_top.sv
`timescale 1ns/1ps

`include "zx_defines.svh"

module zx_mem_top (
	input  logic                    fclk,
	input  logic                    rst,
	input  logic [15:0]             a,
	input  logic [7:0]              d_in,
	output logic [7:0]              d_out,
	output logic                    d_oe,
	input  logic                    iorq_n,
	input  logic                    mreq_n,
	input  logic                    rd_n,
	input  logic                    wr_n,
	input  logic                    m1_n,
	output logic                    csrom,
	output logic                    romoe_n,
	output logic [`ZX_ROM_PG_W-1:0] rompg,
	output logic [`ZX_RAM_PG_W-1:0] ram_page,
	output logic                    dos_n,
	output logic [2:0]              border,
	output logic                    beep
);

	z80_cycle_if bus ();
	port_cfg_if  cfg ();

	zx_pkg::page_word_t win_page [`ZX_NUM_WIN];
	logic               dos;

	z80_bus_decoder u_decoder (
		.fclk   (fclk),
		.rst    (rst),
		.a      (a),
		.d_in   (d_in),
		.iorq_n (iorq_n),
		.mreq_n (mreq_n),
		.rd_n   (rd_n),
		.wr_n   (wr_n),
		.m1_n   (m1_n),
		.bus    (bus.source)
	);

	port_regs u_ports (
		.fclk   (fclk),
		.rst    (rst),
		.bus    (bus.sink),
		.cfg    (cfg.source),
		.d_out  (d_out),
		.d_oe   (d_oe),
		.border (border),
		.beep   (beep)
	);

	// one pager per 16k window
	for (genvar w = 0; w < `ZX_NUM_WIN; w++)
	begin : g_win
		window_pager #(.WIN(w)) u_pager (
			.fclk (fclk),
			.rst  (rst),
			.bus  (bus.sink),
			.cfg  (cfg.sink),
			.dos  (dos),
			.page (win_page[w])
		);
	end

	mem_mapper u_mapper (
		.fclk     (fclk),
		.rst      (rst),
		.bus      (bus.sink),
		.cfg      (cfg.sink),
		.win_page (win_page),
		.a_hi     (a[15:14]),
		.mreq_n   (mreq_n),
		.rd_n     (rd_n),
		.dos      (dos),
		.dos_n    (dos_n),
		.csrom    (csrom),
		.romoe_n  (romoe_n),
		.rompg    (rompg),
		.ram_page (ram_page)
	);

endmodule

// File: dv/zx_mem_tests.svh
// pentagon layout straight out of reset
task automatic reset_layout;
	reset_dut();
	check_map(16'h0000, 1'b0, 7'd0, "reset 0000");
	check_map(16'h4000, 1'b1, 7'd5, "reset 4000");
	check_map(16'h8000, 1'b1, 7'd2, "reset 8000");
	check_map(16'hC000, 1'b1, 7'd0, "reset c000");
	check_val(16'(dos_n), 16'd1, "reset dos_n");
	check_val(16'(d_oe), 16'd0, "reset d_oe");
endtask

task automatic p7ffd_paging;
	logic [7:0] rd;
	logic       oe;
	reset_dut();
	// ram 3 up top with the basic48 rom
	io_write(16'h7FFD, 8'h13);
	check_map(16'hC000, 1'b1, 7'd3, "7ffd=13 window 3");
	check_map(16'h0000, 1'b0, 7'd1, "7ffd=13 window 0");
	io_read(16'h7FFD, rd, oe);
	check_val(16'(oe), 16'd1, "7ffd read d_oe");
	check_val(16'(rd), 16'h0013, "7ffd readback");
	// bit 5 locks the port from here on
	io_write(16'h7FFD, 8'h26);
	check_map(16'hC000, 1'b1, 7'd6, "7ffd=26 window 3");
	check_map(16'h0000, 1'b0, 7'd0, "7ffd=26 window 0");
	io_write(16'h7FFD, 8'h11);
	check_map(16'hC000, 1'b1, 7'd6, "locked 7ffd window 3");
	check_map(16'h0000, 1'b0, 7'd0, "locked 7ffd window 0");
	io_read(16'h7FFD, rd, oe);
	check_val(16'(rd), 16'h0026, "locked 7ffd readback");
	// reset clears the lock
	reset_dut();
	io_write(16'h7FFD, 8'h01);
	check_map(16'hC000, 1'b1, 7'd1, "7ffd after reset");
endtask

task automatic eff7_modes;
	logic [7:0] rd;
	logic       oe;
	reset_dut();
	// bits 7..6 on top of bits 2..0 while eff7 bit 2 is clear
	io_write(16'h7FFD, 8'hC5);
	check_map(16'hC000, 1'b1, {2'b11, 3'b101}, "512k extension");
	io_write(`ZX_PORT_EFF7, 8'h04);
	check_map(16'hC000, 1'b1, 7'd5, "128k only");
	check_map(16'h0000, 1'b0, 7'd0, "eff7=04 window 0");
	io_write(`ZX_PORT_EFF7, 8'h08);
	check_map(16'h0000, 1'b1, 7'd0, "ram0 at 0000");
	check_map(16'hC000, 1'b1, {2'b11, 3'b101}, "eff7=08 window 3");
	io_read(`ZX_PORT_EFF7, rd, oe);
	check_val(16'(oe), 16'd1, "eff7 read d_oe");
	check_val(16'(rd), 16'h0008, "eff7 readback");
	// fe is write only
	io_read(16'h00FE, rd, oe);
	check_val(16'(oe), 16'd0, "fe read d_oe");
endtask

task automatic atm_pager;
	logic [7:0] pg [4];
	reset_dut();
	// A8 high turns the pager on and A9 high keeps cpm off
	io_write(16'h0377, 8'h00);
	for (int round = 0; round < 3; round++)
	begin
		for (int w = 0; w < 4; w++)
		begin
			rand_byte(pg[w]);
			io_write({2'(w), 6'h00, `ZX_PORT_LO_F7}, pg[w]);
		end
		// read all four back after the writes to catch cross writes
		for (int w = 0; w < 4; w++)
			check_map({2'(w), 14'h0123}, pg[w][7], pg[w][6:0], "pager window");
	end
	check_val(16'(dos_n), 16'd1, "pager dos_n");
endtask

task automatic dos_trap;
	reset_dut();
	// no trap with the 128 rom selected
	m1_fetch(16'h3D00);
	check_map(16'h0000, 1'b0, 7'd0, "128 rom fetch 3d00");
	check_val(16'(dos_n), 16'd1, "no trap dos_n");
	io_write(16'h7FFD, 8'h10);
	check_map(16'h0000, 1'b0, 7'd1, "basic48 rom");
	m1_fetch(16'h3D00);
	check_map(16'h0000, 1'b0, 7'd3, "dos rom");
	check_val(16'(dos_n), 16'd0, "trap dos_n");
	m1_fetch(16'h8000);
	check_map(16'h0000, 1'b0, 7'd1, "dos left");
	check_val(16'(dos_n), 16'd1, "leave dos_n");
	// A9 low means cpm mode
	io_write(16'h0077, 8'h00);
	check_map(16'h0000, 1'b0, 7'd3, "cpm rom");
	check_val(16'(dos_n), 16'd0, "cpm dos_n");
	// dos_n stays low on every cycle of the fetch
	fork
		m1_fetch(16'h8000);
		repeat (6)
		begin
			@(negedge fclk);
			check_val(16'(dos_n), 16'd0, "cpm holds dos_n");
		end
	join
endtask

task automatic probe_romoe(input logic [15:0] addr, input logic mq_n, input logic rdn,
	input logic exp, input string what);
	@(posedge fclk);
	a      <= addr;
	mreq_n <= mq_n;
	rd_n   <= rdn;
	@(negedge fclk);
	check_val(16'(romoe_n), 16'(exp), what);
	@(posedge fclk);
	mreq_n <= 1'b1;
	rd_n   <= 1'b1;
endtask

task automatic border_and_romoe;
	logic [7:0] v;
	reset_dut();
	repeat (4)
	begin
		rand_byte(v);
		io_write({8'h00, `ZX_PORT_LO_FE}, v);
		@(negedge fclk);
		check_val(16'(border), 16'(v[2:0]), "border");
		check_val(16'(beep), 16'(v[4]), "beep");
	end
	probe_romoe(16'h0000, 1'b0, 1'b0, 1'b0, "rom read romoe_n");
	probe_romoe(16'h8000, 1'b0, 1'b0, 1'b1, "ram read romoe_n");
	probe_romoe(16'h0000, 1'b1, 1'b0, 1'b1, "no mreq romoe_n");
	probe_romoe(16'h0000, 1'b0, 1'b1, 1'b1, "no rd romoe_n");
endtask

// File: dv/zx_mem_tb.sv
`timescale 1ns/1ps

`include "zx_defines.svh"

module zx_mem_tb;

	localparam int CLK_PERIOD      = 10;
	localparam int NUM_TESTS       = 6;
	localparam int CYCLES_PER_TEST = 2000;

	logic                    fclk;
	logic                    rst;
	logic [15:0]             a;
	logic [7:0]              d_in;
	logic [7:0]              d_out;
	logic                    d_oe;
	logic                    iorq_n;
	logic                    mreq_n;
	logic                    rd_n;
	logic                    wr_n;
	logic                    m1_n;
	logic                    csrom;
	logic                    romoe_n;
	logic [`ZX_ROM_PG_W-1:0] rompg;
	logic [`ZX_RAM_PG_W-1:0] ram_page;
	logic                    dos_n;
	logic [2:0]              border;
	logic                    beep;

	int          errors;
	logic [31:0] lfsr_state;

	zx_mem_top DUT (.*);

	initial
	begin
		fclk = 1'b0;
		forever #(CLK_PERIOD / 2) fclk = ~fclk;
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////////////////////////

	// galois form, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	// one lfsr step per bit
	task automatic rand_byte(output logic [7:0] v);
		for (int i = 0; i < 8; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			v[i] = lfsr_state[0];
		end
	endtask

	task automatic reset_dut;
		@(posedge fclk);
		rst <= 1'b1;
		repeat (3) @(posedge fclk);
		rst <= 1'b0;
	endtask

	task automatic check_val(input logic [15:0] got, input logic [15:0] exp, input string what);
		assert (got === exp)
		else
		begin
			$display("MISMATCH at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
			errors++;
		end
	endtask

	// z80 bus cycles, strobes held low for 4 fclk
	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge fclk);
		a      <= addr;
		d_in   <= data;
		iorq_n <= 1'b0;
		wr_n   <= 1'b0;
		repeat (4) @(posedge fclk);
		iorq_n <= 1'b1;
		wr_n   <= 1'b1;
	endtask

	task automatic io_read(input logic [15:0] addr, output logic [7:0] data, output logic oe);
		@(posedge fclk);
		a      <= addr;
		iorq_n <= 1'b0;
		rd_n   <= 1'b0;
		repeat (3) @(posedge fclk);
		// d_oe trails io_rd by one cycle
		@(negedge fclk);
		data = d_out;
		oe   = d_oe;
		@(posedge fclk);
		iorq_n <= 1'b1;
		rd_n   <= 1'b1;
	endtask

	task automatic m1_fetch(input logic [15:0] addr);
		@(posedge fclk);
		a      <= addr;
		mreq_n <= 1'b0;
		m1_n   <= 1'b0;
		rd_n   <= 1'b0;
		repeat (4) @(posedge fclk);
		mreq_n <= 1'b1;
		m1_n   <= 1'b1;
		rd_n   <= 1'b1;
	endtask

	// mapping outputs are combinational from the address
	task automatic check_map(input logic [15:0] addr, input logic is_ram,
		input logic [6:0] pg, input string what);
		@(posedge fclk);
		a <= addr;
		@(negedge fclk);
		check_val(16'(csrom), 16'(!is_ram), {what, " csrom"});
		if (is_ram)
			check_val(16'(ram_page), 16'(pg), {what, " ram page"});
		else
			check_val(16'(rompg), 16'(pg[4:0]), {what, " rom page"});
	endtask

	`include "zx_mem_tests.svh"

	//////////////////////////////////////////////////////////////////////
	// main sequence and watchdog
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		rst        <= 1'b1;
		a          <= 16'h0000;
		d_in       <= 8'h00;
		iorq_n     <= 1'b1;
		mreq_n     <= 1'b1;
		rd_n       <= 1'b1;
		wr_n       <= 1'b1;
		m1_n       <= 1'b1;
		errors     = 0;
		lfsr_state = 32'h5ef4_475f;
		reset_dut();
		reset_layout();
		p7ffd_paging();
		eff7_modes();
		atm_pager();
		dos_trap();
		border_and_romoe();
		$display("all tests done, %0d errors", errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		#(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
		$display("timeout, tests did not finish in %0d cycles, %0d errors so far",
			NUM_TESTS * CYCLES_PER_TEST, errors);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+hdl
+incdir+dv
hdl/zx_pkg.sv
hdl/zx_ifaces.sv
hdl/z80_bus_decoder.sv
hdl/port_regs.sv
hdl/window_pager.sv
hdl/mem_mapper.sv
hdl/zx_mem_top.sv
dv/zx_mem_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module zx_mem_tb -o zx_mem_sim

out=$(./obj_dir/zx_mem_sim)
echo "$out"

if grep -q "TEST PASSED" <<< "$out"; then
	exit 0
else
	exit 1
fi
